// File: rtl/noc_defs.svh
// NoC configuration macros
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Mesh size in columns (x) and rows (y)
`define NOC_NUM_X 3
`define NOC_NUM_Y 3

// User data carried in every flit
`define NOC_PAYLOAD_W 16

// Entries per router input buffer
`define NOC_FIFO_DEPTH 2

// Two entries are enough to keep a link busy
// with a registered ready path

// One flit per packet and one channel per link,
// so nothing else is configurable here

`endif

// File: rtl/noc_pkg.sv
// NoC shared types
`include "noc_defs.svh"

package noc_pkg;

  // Local plus the four neighbor links
  localparam int unsigned NUM_PORTS = 5;

  // Coordinate fields wide enough for the larger mesh dimension
  localparam int unsigned MaxDim = (`NOC_NUM_X > `NOC_NUM_Y) ? `NOC_NUM_X : `NOC_NUM_Y;
  localparam int unsigned CoordW = (MaxDim > 1) ? $clog2(MaxDim) : 1;

  typedef logic [CoordW-1:0] coord_val_t;

  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

  typedef struct packed {
    coord_val_t x;
    coord_val_t y;
  } coord_t;

  // Single-flit packet
  typedef struct packed {
    coord_t   dst;
    coord_t   src;
    payload_t data;
  } flit_t;

  // Router port order, also the index into every per-port array
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } port_e;

endpackage

// File: rtl/noc_in_fifo.sv
// Router input buffer
`timescale 1ns/1ps

module noc_in_fifo
  import noc_pkg::*;
#(
  parameter int unsigned Depth = 2
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t flit_i,
  output logic  valid_o,
  input  logic  ready_i,
  output flit_t flit_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  flit_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;

  assign ready_o = (count_q != CntW'(Depth));
  assign valid_o = (count_q != '0);
  assign flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

endmodule

// File: rtl/noc_rr_arbiter.sv
// Round-robin output arbiter
`timescale 1ns/1ps

module noc_rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              ack_i,
  output logic [NumReq-1:0] gnt_o
);

  localparam int unsigned IdxW = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] win_idx;
  logic            found;
  int unsigned     cand;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    gnt_o   = '0;
    win_idx = '0;
    found   = 1'b0;
    cand    = 0;
    for (int unsigned off = 0; off < NumReq; off++) begin
      cand = int'(ptr_q) + off;
      if (cand >= NumReq) begin
        cand = cand - NumReq;
      end
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        win_idx     = IdxW'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // Pointer moves just past the winner once the grant is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (ack_i && found) begin
      if (win_idx == IdxW'(NumReq - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule

// File: rtl/noc_router.sv
// Five-port XY router
`timescale 1ns/1ps
`include "noc_defs.svh"

module noc_router
  import noc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  coord_t                xy_id_i,
  input  logic  [NUM_PORTS-1:0] valid_i,
  output logic  [NUM_PORTS-1:0] ready_o,
  input  flit_t [NUM_PORTS-1:0] flit_i,
  output logic  [NUM_PORTS-1:0] valid_o,
  input  logic  [NUM_PORTS-1:0] ready_i,
  output flit_t [NUM_PORTS-1:0] flit_o
);

  // X first, then Y, eject when both match
  function automatic port_e xy_route(coord_t dst, coord_t here);
    port_e dir;
    if (dst.x > here.x) begin
      dir = East;
    end else if (dst.x < here.x) begin
      dir = West;
    end else if (dst.y > here.y) begin
      dir = North;
    end else if (dst.y < here.y) begin
      dir = South;
    end else begin
      dir = Local;
    end
    return dir;
  endfunction

  // FIFO head side
  logic  [NUM_PORTS-1:0] head_valid;
  logic  [NUM_PORTS-1:0] head_pop;
  flit_t [NUM_PORTS-1:0] head_flit;
  port_e                 head_route [NUM_PORTS];

  // Indexed as [output][input]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_req;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_gnt;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
    noc_in_fifo #(
      .Depth ( `NOC_FIFO_DEPTH )
    ) i_in_fifo (
      .clk_i   ( clk_i         ),
      .rst_i   ( rst_i         ),
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .flit_i  ( flit_i[i]     ),
      .valid_o ( head_valid[i] ),
      .ready_i ( head_pop[i]   ),
      .flit_o  ( head_flit[i]  )
    );

    assign head_route[i] = xy_route(head_flit[i].dst, xy_id_i);
  end

  // Each head requests exactly one output
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        out_req[o][i] = head_valid[i] && (head_route[i] == port_e'(o));
      end
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    noc_rr_arbiter #(
      .NumReq ( NUM_PORTS )
    ) i_arb (
      .clk_i ( clk_i      ),
      .rst_i ( rst_i      ),
      .req_i ( out_req[o] ),
      .ack_i ( ready_i[o] ),
      .gnt_o ( out_gnt[o] )
    );
  end

  // Pop a head when its output takes the flit
  always_comb begin
    head_pop = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (out_gnt[o][i] && ready_i[o]) begin
          head_pop[i] = 1'b1;
        end
      end
    end
  end

  // Crossbar, grants are one-hot per output
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      valid_o[o] = |out_gnt[o];
      flit_o[o]  = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (out_gnt[o][i]) begin
          flit_o[o] = head_flit[i];
        end
      end
    end
  end

endmodule

// File: rtl/noc_mesh.sv
// XY mesh of routers
`timescale 1ns/1ps
`include "noc_defs.svh"

module noc_mesh
  import noc_pkg::*;
#(
  parameter int unsigned NumX = `NOC_NUM_X,
  parameter int unsigned NumY = `NOC_NUM_Y
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic  [NumX-1:0][NumY-1:0]       valid_i,
  output logic  [NumX-1:0][NumY-1:0]       ready_o,
  input  flit_t [NumX-1:0][NumY-1:0]       flit_i,
  output logic  [NumX-1:0][NumY-1:0]       valid_o,
  input  logic  [NumX-1:0][NumY-1:0]       ready_i,
  output flit_t [NumX-1:0][NumY-1:0]       flit_o
);

  // Links between neighbors, pos goes toward higher index
  flit_t [NumX-2:0][NumY-1:0] pos_x_flit, neg_x_flit;
  logic  [NumX-2:0][NumY-1:0] pos_x_valid, pos_x_ready;
  logic  [NumX-2:0][NumY-1:0] neg_x_valid, neg_x_ready;
  flit_t [NumX-1:0][NumY-2:0] pos_y_flit, neg_y_flit;
  logic  [NumX-1:0][NumY-2:0] pos_y_valid, pos_y_ready;
  logic  [NumX-1:0][NumY-2:0] neg_y_valid, neg_y_ready;

  for (genvar x = 0; x < NumX; x++) begin : gen_x
    for (genvar y = 0; y < NumY; y++) begin : gen_y
      coord_t                node_id;
      logic  [NUM_PORTS-1:0] in_valid, in_ready, out_valid, out_ready;
      flit_t [NUM_PORTS-1:0] in_flit, out_flit;

      assign node_id.x = coord_val_t'(x);
      assign node_id.y = coord_val_t'(y);

      // Local port goes straight to the top level
      assign in_valid[Local]  = valid_i[x][y];
      assign in_flit[Local]   = flit_i[x][y];
      assign ready_o[x][y]    = in_ready[Local];
      assign valid_o[x][y]    = out_valid[Local];
      assign flit_o[x][y]     = out_flit[Local];
      assign out_ready[Local] = ready_i[x][y];

      if (y < NumY - 1) begin : gen_north
        assign in_valid[North]   = neg_y_valid[x][y];
        assign in_flit[North]    = neg_y_flit[x][y];
        assign neg_y_ready[x][y] = in_ready[North];
        assign pos_y_valid[x][y] = out_valid[North];
        assign pos_y_flit[x][y]  = out_flit[North];
        assign out_ready[North]  = pos_y_ready[x][y];
      end else begin : gen_north_edge
        assign in_valid[North]  = 1'b0;
        assign in_flit[North]   = '0;
        assign out_ready[North] = 1'b0;
      end

      if (y > 0) begin : gen_south
        assign in_valid[South]     = pos_y_valid[x][y-1];
        assign in_flit[South]      = pos_y_flit[x][y-1];
        assign pos_y_ready[x][y-1] = in_ready[South];
        assign neg_y_valid[x][y-1] = out_valid[South];
        assign neg_y_flit[x][y-1]  = out_flit[South];
        assign out_ready[South]    = neg_y_ready[x][y-1];
      end else begin : gen_south_edge
        assign in_valid[South]  = 1'b0;
        assign in_flit[South]   = '0;
        assign out_ready[South] = 1'b0;
      end

      if (x < NumX - 1) begin : gen_east
        assign in_valid[East]    = neg_x_valid[x][y];
        assign in_flit[East]     = neg_x_flit[x][y];
        assign neg_x_ready[x][y] = in_ready[East];
        assign pos_x_valid[x][y] = out_valid[East];
        assign pos_x_flit[x][y]  = out_flit[East];
        assign out_ready[East]   = pos_x_ready[x][y];
      end else begin : gen_east_edge
        assign in_valid[East]  = 1'b0;
        assign in_flit[East]   = '0;
        assign out_ready[East] = 1'b0;
      end

      if (x > 0) begin : gen_west
        assign in_valid[West]      = pos_x_valid[x-1][y];
        assign in_flit[West]       = pos_x_flit[x-1][y];
        assign pos_x_ready[x-1][y] = in_ready[West];
        assign neg_x_valid[x-1][y] = out_valid[West];
        assign neg_x_flit[x-1][y]  = out_flit[West];
        assign out_ready[West]     = neg_x_ready[x-1][y];
      end else begin : gen_west_edge
        assign in_valid[West]  = 1'b0;
        assign in_flit[West]   = '0;
        assign out_ready[West] = 1'b0;
      end

      noc_router i_router (
        .clk_i   ( clk_i     ),
        .rst_i   ( rst_i     ),
        .xy_id_i ( node_id   ),
        .valid_i ( in_valid  ),
        .ready_o ( in_ready  ),
        .flit_i  ( in_flit   ),
        .valid_o ( out_valid ),
        .ready_i ( out_ready ),
        .flit_o  ( out_flit  )
      );
    end
  end

endmodule

// File: sim/noc_tb.sv
// NoC mesh testbench
`timescale 1ns/1ps
`include "noc_defs.svh"

module noc_tb
  import noc_pkg::*;
();

  localparam int NX = `NOC_NUM_X;
  localparam int NY = `NOC_NUM_Y;
  localparam int NN = NX * NY;
  localparam int DRIVE_DLY = 2;
  localparam int RESET_CYC = 10;
  localparam int IDLE_CYC = 20;
  localparam int HOLD_CYC = 40;
  localparam int MAX_STREAM = 16;
  localparam int MAX_GAP = 2;
  localparam int RAND_FLITS = NN * 8;
  // All-pairs, burst, back-pressure, random and contention phases
  localparam int TOTAL_FLITS = NN * NN + 16 + 32 + RAND_FLITS + 24;
  localparam int WORST_LAT = (NX + NY - 1) * NUM_PORTS;
  localparam int TIMEOUT_CYC = 2 * (TOTAL_FLITS * WORST_LAT + RESET_CYC + IDLE_CYC
                                    + HOLD_CYC + MAX_GAP * RAND_FLITS) + 500;

  typedef struct packed {
    flit_t       f;
    logic [31:0] cyc;
  } inj_rec_t;

  logic clk = 1'b0;
  logic rst;
  logic  [NX-1:0][NY-1:0] valid_i, ready_o, valid_o, ready_i;
  flit_t [NX-1:0][NY-1:0] flit_i, flit_o;

  inj_rec_t    exp_q [NN][NN][$];
  int          stim_len [NN];
  int          stim_dst [NN][MAX_STREAM];
  int          stim_gap [NN][MAX_STREAM];
  int unsigned cyc_cnt = 0;
  int          pending = 0;
  int          err_value = 0;
  int          err_other = 0;
  int          seq = 0;
  int          left_over;
  bit          exact_lat = 1'b0;
  bit          streams_done;
  bit          fair_on = 1'b0;
  int          fair_a, fair_b, fair_dst;
  int          last_src = -1;
  int          run_len = 0;

  noc_mesh DUT (
    .clk_i   ( clk     ),
    .rst_i   ( rst     ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .flit_i  ( flit_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .flit_o  ( flit_o  )
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  function automatic coord_t mk_coord(int n);
    coord_t c;
    c.x = coord_val_t'(n / NY);
    c.y = coord_val_t'(n % NY);
    return c;
  endfunction

  function automatic int node_idx(coord_t c);
    return int'(c.x) * NY + int'(c.y);
  endfunction

  function automatic bit coord_ok(coord_t c);
    return (int'(c.x) < NX) && (int'(c.y) < NY);
  endfunction

  // One cycle per router on the XY path
  function automatic int noc_expected_latency(coord_t src, coord_t dst);
    int dx, dy;
    dx = (dst.x > src.x) ? int'(dst.x) - int'(src.x) : int'(src.x) - int'(dst.x);
    dy = (dst.y > src.y) ? int'(dst.y) - int'(src.y) : int'(src.y) - int'(dst.y);
    return dx + dy + 1;
  endfunction

  function automatic flit_t make_flit(int s, int d);
    flit_t f;
    f.dst  = mk_coord(d);
    f.src  = mk_coord(s);
    f.data = payload_t'(seq);
    seq++;
    return f;
  endfunction

  task automatic check_flit(flit_t got, flit_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: flit got %h expected %h", $time, got, exp);
      err_value++;
    end
  endtask

  task automatic check_coord(coord_t got, coord_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: flit for node %h ejected at node %h", $time, exp, got);
      err_value++;
    end
  endtask

  task automatic check_latency(int got, int exp, bit exact);
    if ((exact && got != exp) || (!exact && got < exp)) begin
      $display("[ERROR] %0t: latency %0d cycles, expected %s%0d", $time, got,
               exact ? "" : "at least ", exp);
      err_value++;
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      err_value++;
    end
  endtask

  task automatic handle_eject(int n, flit_t f);
    inj_rec_t rec;
    int       s, d;
    if (!coord_ok(f.src) || !coord_ok(f.dst) ||
        exp_q[node_idx(f.src)][node_idx(f.dst)].size() == 0) begin
      $display("Unexpected flit %h ejected at node %0d with no matching injection", f, n);
      err_other++;
    end else begin
      s   = node_idx(f.src);
      d   = node_idx(f.dst);
      rec = exp_q[s][d].pop_front();
      pending--;
      check_coord(mk_coord(n), f.dst);
      check_flit(f, rec.f);
      check_latency(int'(cyc_cnt - rec.cyc), noc_expected_latency(f.src, f.dst), exact_lat);
      if (fair_on && d == fair_dst) begin
        run_len  = (s == last_src) ? run_len + 1 : 1;
        last_src = s;
        if (run_len > NUM_PORTS && exp_q[(s == fair_a) ? fair_b : fair_a][d].size() != 0) begin
          $display("[ERROR] %0t: node %0d served %0d times in a row", $time, s, run_len);
          err_value++;
        end
      end
    end
  endtask

  // Handshakes complete at the next rising edge, so sample in between
  always @(negedge clk) begin
    if (!rst) begin
      for (int n = 0; n < NN; n++) begin
        if (valid_i[n / NY][n % NY] && ready_o[n / NY][n % NY]) begin
          exp_q[node_idx(flit_i[n / NY][n % NY].src)]
               [node_idx(flit_i[n / NY][n % NY].dst)].push_back({flit_i[n / NY][n % NY],
                                                                  32'(cyc_cnt)});
          pending++;
        end
      end
      for (int n = 0; n < NN; n++) begin
        if (valid_o[n / NY][n % NY] && ready_i[n / NY][n % NY]) begin
          handle_eject(n, flit_o[n / NY][n % NY]);
        end
      end
    end
  end

  task automatic next_drive();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic inject_flit(int n, flit_t f);
    valid_i[n / NY][n % NY] = 1'b1;
    flit_i[n / NY][n % NY]  = f;
    @(negedge clk);
    while (!ready_o[n / NY][n % NY]) begin
      @(negedge clk);
    end
    next_drive();
    valid_i[n / NY][n % NY] = 1'b0;
  endtask

  task automatic send_stream(int n);
    for (int k = 0; k < stim_len[n]; k++) begin
      repeat (stim_gap[n][k]) next_drive();
      inject_flit(n, make_flit(n, stim_dst[n][k]));
    end
  endtask

  task automatic run_streams();
    for (int n = 0; n < NN; n++) begin
      automatic int nn = n;
      fork
        send_stream(nn);
      join_none
    end
    wait fork;
  endtask

  task automatic set_stream(int n, int dst, int len);
    stim_len[n] = len;
    for (int k = 0; k < len; k++) begin
      stim_dst[n][k] = dst;
      stim_gap[n][k] = 0;
    end
  endtask

  task automatic clear_stim();
    for (int n = 0; n < NN; n++) begin
      stim_len[n] = 0;
    end
  endtask

  task automatic wait_drain();
    while (pending != 0) begin
      next_drive();
    end
  endtask

  initial begin : watchdog
    wait (cyc_cnt >= TIMEOUT_CYC);
    $display("Run timed out after %0d cycles with %0d flits in flight", cyc_cnt, pending);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'hfef7e976));
    rst     = 1'b1;
    valid_i = '0;
    flit_i  = '0;
    ready_i = '1;
    repeat (RESET_CYC) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // Quiet mesh after reset
    repeat (IDLE_CYC) begin
      @(negedge clk);
      for (int n = 0; n < NN; n++) begin
        check_flag(valid_o[n / NY][n % NY], 1'b0, "idle valid_o");
        check_flag(ready_o[n / NY][n % NY], 1'b1, "idle ready_o");
      end
    end
    next_drive();

    // Every pair with one flit in flight at a time
    exact_lat = 1'b1;
    for (int s = 0; s < NN; s++) begin
      for (int d = 0; d < NN; d++) begin
        inject_flit(s, make_flit(s, d));
        wait_drain();
      end
    end
    exact_lat = 1'b0;

    // Burst from corner to corner
    clear_stim();
    set_stream(0, NN - 1, MAX_STREAM);
    run_streams();
    wait_drain();

    // Neighbors of the center node while it refuses flits
    clear_stim();
    set_stream(1 * NY + 0, 1 * NY + 1, 8);
    set_stream(1 * NY + 2, 1 * NY + 1, 8);
    set_stream(0 * NY + 1, 1 * NY + 1, 8);
    set_stream(2 * NY + 1, 1 * NY + 1, 8);
    ready_i[1][1] = 1'b0;
    fork
      run_streams();
    join_none
    repeat (HOLD_CYC) next_drive();
    // Each source fills its local buffer and one input buffer of the center node
    check_flag(pending == 4 * 2 * `NOC_FIFO_DEPTH, 1'b1, "flits held for blocked node");
    check_flag(ready_o[1][0], 1'b0, "stalled source ready_o");
    check_flag(ready_o[1][2], 1'b0, "stalled source ready_o");
    check_flag(ready_o[0][1], 1'b0, "stalled source ready_o");
    check_flag(ready_o[2][1], 1'b0, "stalled source ready_o");
    ready_i[1][1] = 1'b1;
    wait fork;
    wait_drain();

    // Random all-to-all traffic with random sink stalls
    for (int n = 0; n < NN; n++) begin
      stim_len[n] = RAND_FLITS / NN;
      for (int k = 0; k < stim_len[n]; k++) begin
        stim_dst[n][k] = $urandom_range(NN - 1);
        stim_gap[n][k] = $urandom_range(MAX_GAP);
      end
    end
    streams_done = 1'b0;
    fork
      begin
        run_streams();
        streams_done = 1'b1;
      end
    join_none
    while (!streams_done) begin
      for (int n = 0; n < NN; n++) begin
        ready_i[n / NY][n % NY] = ($urandom_range(3) != 0);
      end
      next_drive();
    end
    ready_i = '1;
    wait fork;
    wait_drain();

    // Two sources contending for one local output
    clear_stim();
    fair_a   = 0;
    fair_b   = 2;
    fair_dst = 1;
    set_stream(fair_a, fair_dst, 12);
    set_stream(fair_b, fair_dst, 12);
    fair_on = 1'b1;
    run_streams();
    wait_drain();
    fair_on = 1'b0;

    repeat (5) next_drive();
    left_over = 0;
    for (int s = 0; s < NN; s++) begin
      for (int d = 0; d < NN; d++) begin
        left_over += exp_q[s][d].size();
      end
    end
    $display("Done: %0d value errors, %0d unexpected flits, %0d flits never delivered",
             err_value, err_other, left_over);
    if (err_value == 0 && err_other == 0 && left_over == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/noc_in_fifo.sv
rtl/noc_rr_arbiter.sv
rtl/noc_router.sv
rtl/noc_mesh.sv
sim/noc_tb.sv

// File: Bender.yml
package:
  name: noc_mesh

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/noc_pkg.sv
      - rtl/noc_in_fifo.sv
      - rtl/noc_rr_arbiter.sv
      - rtl/noc_router.sv
      - rtl/noc_mesh.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/noc_tb.sv
